/* src.f */
hw/matmul_pkg.sv
hw/slice_control.sv
hw/weight_unpack.sv
hw/operand_buffer.sv
hw/mac_array.sv
hw/out_queue.sv
hw/matmul_top.sv
sim/tb_matmul.sv

/* run.sh */
#!/usr/bin/env bash
# builds the matmul testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_matmul -f src.f --Mdir obj_dir -o sim_matmul

./obj_dir/sim_matmul | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"
exit 0

/* sim/tb_matmul.sv */
//********************************************************************
// matmul testbench
// feeds packed weights and activations group by group, keeps a
// reference of the 18-bit accumulators and checks every result byte
// streamed out after each readout pulse
//********************************************************************

`default_nettype none

module tb_matmul;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SLICES = 6;
    localparam int ROWS = 3 * SLICES;
    localparam int ENTRIES = ROWS * SLICES;
    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES = 12;
    localparam int EXTREME_GROUPS = 600;
    localparam int RUN_GROUPS = 1 + 8 + 16 + EXTREME_GROUPS;
    // data groups, flush and readout groups of four runs, four streams
    localparam int TOTAL_CYCLES = RESET_CYCLES + 2 * IDLE_CYCLES
        + (RUN_GROUPS + 2 * 4) * SLICES + 4 * ENTRIES;

    logic              clk;
    logic              reset;
    logic [7:0]        weights;
    logic signed [7:0] act;
    logic              read_out;
    logic [7:0]        result;

    // slot index that the next driven cycle will carry
    int next_slot;
    int error_count = 0;
    int check_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic [31:0] lcg_state = 32'hb31ebb70;

    int grp_code [SLICES];
    int grp_act [SLICES];
    logic signed [17:0] ref_acc [ROWS][SLICES];

    // expected bytes of the run waiting for its readout, and of the stream
    logic [7:0] pend_exp [ENTRIES];
    logic [7:0] cur_exp [ENTRIES];
    string      pend_name;
    string      cur_name;
    logic       stream_active = 1'b0;
    int         stream_idx;
    int         stream_err_base;

    matmul_top #(
        .SLICES(SLICES)
    ) i_matmul_top (
        .clk     (clk),
        .reset   (reset),
        .weights (weights),
        .act     (act),
        .read_out(read_out),
        .result  (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // product of one decoded weight and an activation
    // offset 2 picks the base-5 digit, 1 and 0 the middle and top base-7 digits
    function automatic int weight_times_act(input int code, input int offset, input int a);
        int digit;
        int half;
        half = a >>> 1;
        if (code >= 245) begin
            return 0;
        end
        if (offset == 2) begin
            digit = code % 5;
            case (digit)
                1:       return a;
                2:       return 2 * a;
                3:       return -a;
                4:       return -2 * a;
                default: return 0;
            endcase
        end
        digit = (offset == 1) ? (code / 5) % 7 : (code / 5) / 7;
        case (digit)
            1:       return half;
            2:       return a;
            3:       return 2 * a;
            4:       return -half;
            5:       return -a;
            6:       return -2 * a;
            default: return 0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errors);
        tests_run++;
        if (errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors);
        end
    endtask

    task automatic drive_cycle(input logic [7:0] w, input int a, input logic ro);
        @(posedge clk);
        weights  <= w;
        act      <= 8'(a);
        read_out <= ro;
        next_slot = ro ? 1 : (next_slot + 1) % SLICES;
    endtask

    task automatic pad_to_group();
        while (next_slot != 0) begin
            drive_cycle(8'd0, 0, 1'b0);
        end
    endtask

    task automatic wait_stream_idle();
        while (stream_active) begin
            drive_cycle(8'd0, 0, 1'b0);
        end
        pad_to_group();
    endtask

    task automatic start_run();
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < SLICES; c++) begin
                ref_acc[r][c] = '0;
            end
        end
    endtask

    // drives grp_code/grp_act as one group and adds it to the reference
    task automatic feed_group();
        for (int k = 0; k < SLICES; k++) begin
            drive_cycle(8'(grp_code[k]), grp_act[k], 1'b0);
        end
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < SLICES; c++) begin
                ref_acc[r][c] = ref_acc[r][c]
                    + 18'(weight_times_act(grp_code[r / 3], r % 3, grp_act[c]));
            end
        end
    endtask

    // flush group, then readout on slot 0 of the next group
    task automatic finish_run(input string name);
        for (int k = 0; k < SLICES; k++) begin
            drive_cycle(8'd0, 0, 1'b0);
        end
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < SLICES; c++) begin
                pend_exp[r * SLICES + c] = ref_acc[r][c][16:9];
            end
        end
        pend_name = name;
        drive_cycle(8'd0, 0, 1'b1);
        pad_to_group();
    endtask

    // result entry n is due in the (n+1)-th cycle after the readout edge
    always @(negedge clk) begin
        if (!reset) begin
            if (stream_active) begin
                check_value($sformatf("result[%0d]", stream_idx),
                            32'(cur_exp[stream_idx]), 32'(result));
                stream_idx++;
                if (stream_idx == ENTRIES) begin
                    stream_active = 1'b0;
                    report_test(cur_name, error_count - stream_err_base);
                end
            end else begin
                check_value("result", 32'd0, 32'(result));
            end
            if (read_out) begin
                cur_exp = pend_exp;
                cur_name = pend_name;
                stream_idx = 0;
                stream_err_base = error_count;
                stream_active = 1'b1;
            end
        end
    end

    initial begin
        #(TOTAL_CYCLES * 2 * CLK_PERIOD);
        $display("timeout: result stream did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int idle_base;
        reset    = 1'b1;
        weights  = 8'd0;
        act      = 8'sd0;
        read_out = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        // the idle inputs held at release are slot 0
        next_slot = 1;

        idle_base = error_count;
        repeat (IDLE_CYCLES) drive_cycle(8'd0, 0, 1'b0);
        report_test("reset value", error_count - idle_base);

        // every weight is 1, so each entry is the activation's sign
        pad_to_group();
        start_run();
        grp_act = '{-100, 50, -1, 127, -128, 0};
        for (int k = 0; k < SLICES; k++) begin
            grp_code[k] = 81;
        end
        feed_group();
        finish_run("single group");

        wait_stream_idle();
        start_run();
        for (int g = 0; g < 8; g++) begin
            for (int k = 0; k < SLICES; k++) begin
                lcg_state = lcg_next(lcg_state);
                grp_code[k] = int'(lcg_state[31:24]);
                lcg_state = lcg_next(lcg_state);
                grp_act[k] = int'($signed(lcg_state[23:16]));
            end
            if (g == 3) begin
                grp_code[2] = 247;
            end
            feed_group();
        end
        finish_run("random groups");

        // second run fed while the first one streams out
        start_run();
        for (int g = 0; g < 16; g++) begin
            for (int k = 0; k < SLICES; k++) begin
                lcg_state = lcg_next(lcg_state);
                grp_code[k] = int'(lcg_state[31:24]);
                lcg_state = lcg_next(lcg_state);
                grp_act[k] = int'($signed(lcg_state[23:16]));
            end
            feed_group();
        end
        finish_run("back to back");

        // weights -2 and 2 against -128 and 127 until the sums wrap
        wait_stream_idle();
        start_run();
        for (int k = 0; k < SLICES; k++) begin
            grp_code[k] = (k % 2 == 0) ? 244 : 122;
            grp_act[k] = (k % 2 == 0) ? -128 : 127;
        end
        for (int g = 0; g < EXTREME_GROUPS; g++) begin
            feed_group();
        end
        finish_run("extreme values");

        wait_stream_idle();
        idle_base = error_count;
        repeat (IDLE_CYCLES) drive_cycle(8'd0, 0, 1'b0);
        @(posedge clk);
        report_test("drained queue", error_count - idle_base);

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/matmul_top.sv */
//********************************************************************
// matmul top
// outer-product matrix-multiply engine with packed weights and
// signed 8-bit activations, results streamed out byte by byte
//********************************************************************

`default_nettype none

module matmul_top #(
    parameter int SLICES = 6
) (
    input  logic                clk,
    input  logic                reset,
    input  matmul_pkg::w_byte_t weights,
    input  matmul_pkg::act_t    act,
    input  logic                read_out,
    output matmul_pkg::res_t    result
);

    localparam int ROWS = matmul_pkg::ROWS_PER_SLOT * SLICES;

    logic                                 group_last;
    logic [matmul_pkg::ROWS_PER_SLOT-1:0] zero;
    logic [matmul_pkg::ROWS_PER_SLOT-1:0] sign;
    logic [matmul_pkg::ROWS_PER_SLOT-1:0] mul2;
    logic [matmul_pkg::ROWS_PER_SLOT-1:0] div2;
    logic [ROWS-1:0]                      row_zero;
    logic [ROWS-1:0]                      row_sign;
    logic [ROWS-1:0]                      row_mul2;
    logic [ROWS-1:0]                      row_div2;
    matmul_pkg::act_t                     act_head;
    matmul_pkg::acc_t [ROWS*SLICES-1:0]   acc_result;

    slice_control #(
        .SLICES(SLICES)
    ) i_slice_control (
        .clk       (clk),
        .reset     (reset),
        .read_out  (read_out),
        .group_last(group_last)
    );

    weight_unpack i_weight_unpack (
        .weights(weights),
        .zero   (zero),
        .sign   (sign),
        .mul2   (mul2),
        .div2   (div2)
    );

    operand_buffer #(
        .SLICES(SLICES)
    ) i_operand_buffer (
        .clk       (clk),
        .reset     (reset),
        .read_out  (read_out),
        .group_last(group_last),
        .zero      (zero),
        .sign      (sign),
        .mul2      (mul2),
        .div2      (div2),
        .act       (act),
        .row_zero  (row_zero),
        .row_sign  (row_sign),
        .row_mul2  (row_mul2),
        .row_div2  (row_div2),
        .act_head  (act_head)
    );

    mac_array #(
        .SLICES(SLICES)
    ) i_mac_array (
        .clk       (clk),
        .reset     (reset),
        .read_out  (read_out),
        .row_zero  (row_zero),
        .row_sign  (row_sign),
        .row_mul2  (row_mul2),
        .row_div2  (row_div2),
        .act_head  (act_head),
        .acc_result(acc_result)
    );

    out_queue #(
        .SLICES(SLICES)
    ) i_out_queue (
        .clk       (clk),
        .reset     (reset),
        .read_out  (read_out),
        .acc_result(acc_result),
        .result    (result)
    );

endmodule

`default_nettype wire

/* hw/out_queue.sv */
//********************************************************************
// out queue
// takes a snapshot of all accumulators on readout and streams one
// result byte per cycle, row-major, filling with zero behind
//********************************************************************

`default_nettype none

module out_queue #(
    parameter int SLICES = 6,
    localparam int ENTRIES = matmul_pkg::ROWS_PER_SLOT * SLICES * SLICES
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                read_out,
    input  matmul_pkg::acc_t [ENTRIES-1:0]      acc_result,
    output matmul_pkg::res_t                    result
);

    matmul_pkg::acc_t [ENTRIES-1:0] queue;

    always_ff @(posedge clk) begin
        if (reset) begin
            queue <= '0;
        end else if (read_out) begin
            queue <= acc_result;
        end else begin
            // entry 1 moves to the head, zero enters at the tail
            queue <= {matmul_pkg::acc_t'(0), queue[ENTRIES-1:1]};
        end
    end

    // result byte is acc bits 16 down to 9
    assign result = queue[0][matmul_pkg::OUT_SHIFT +: $bits(matmul_pkg::res_t)];

endmodule

`default_nettype wire

/* hw/mac_array.sv */
//********************************************************************
// mac array
// one rotating accumulator ring per row; the ring head adds or
// subtracts the shaped activation while the other entries move on
//********************************************************************

`default_nettype none

module mac_array #(
    parameter int SLICES = 6,
    localparam int ROWS = matmul_pkg::ROWS_PER_SLOT * SLICES
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    read_out,
    input  logic [ROWS-1:0]                         row_zero,
    input  logic [ROWS-1:0]                         row_sign,
    input  logic [ROWS-1:0]                         row_mul2,
    input  logic [ROWS-1:0]                         row_div2,
    input  matmul_pkg::act_t                        act_head,
    output matmul_pkg::acc_t [ROWS*SLICES-1:0]      acc_result
);

    // ring entry 0 is the compute head of each row
    matmul_pkg::acc_t [ROWS-1:0][SLICES-1:0] acc;
    matmul_pkg::acc_t [ROWS-1:0][SLICES-1:0] acc_step;

    matmul_pkg::addend_t               act_wide;
    matmul_pkg::addend_t [ROWS-1:0]    addend;
    matmul_pkg::acc_t    [ROWS-1:0]    head_next;

    // sign extend first so the shifts keep the sign
    assign act_wide = matmul_pkg::addend_t'(act_head);

    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            if (row_mul2[r]) begin
                addend[r] = act_wide <<< 1;
            end else if (row_div2[r]) begin
                // rounds toward minus infinity
                addend[r] = act_wide >>> 1;
            end else begin
                addend[r] = act_wide;
            end

            if (row_zero[r]) begin
                head_next[r] = acc[r][0];
            end else if (row_sign[r]) begin
                head_next[r] = acc[r][0] - matmul_pkg::acc_t'(addend[r]);
            end else begin
                head_next[r] = acc[r][0] + matmul_pkg::acc_t'(addend[r]);
            end

            // entries move one place toward the head, the new sum goes to the tail
            acc_step[r] = {head_next[r], acc[r][SLICES-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset || read_out) begin
            acc <= '0;
        end else begin
            acc <= acc_step;
        end
    end

    // at a group boundary the stepped ring sits one place ahead,
    // column k of row r is found in entry k-1 (wrapping)
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < SLICES; k++) begin
                acc_result[r*SLICES + k] = acc_step[r][(k + SLICES - 1) % SLICES];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/operand_buffer.sv */
//********************************************************************
// operand buffer
// collects one group of weight flags and activations, then hands the
// finished group to the compute side and rotates its activations
//********************************************************************

`default_nettype none

module operand_buffer #(
    parameter int SLICES = 6,
    localparam int ROWS = matmul_pkg::ROWS_PER_SLOT * SLICES
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  read_out,
    input  logic                                  group_last,
    input  logic [matmul_pkg::ROWS_PER_SLOT-1:0] zero,
    input  logic [matmul_pkg::ROWS_PER_SLOT-1:0] sign,
    input  logic [matmul_pkg::ROWS_PER_SLOT-1:0] mul2,
    input  logic [matmul_pkg::ROWS_PER_SLOT-1:0] div2,
    input  matmul_pkg::act_t                      act,
    output logic [ROWS-1:0]                       row_zero,
    output logic [ROWS-1:0]                       row_sign,
    output logic [ROWS-1:0]                       row_mul2,
    output logic [ROWS-1:0]                       row_div2,
    output matmul_pkg::act_t                      act_head
);

    localparam int RPS = matmul_pkg::ROWS_PER_SLOT;

    // flag planes from the top are zero, sign, mul2, div2
    logic [3:0][RPS-1:0]  slot_flags;
    logic [3:0][ROWS-1:0] flags_next;
    logic [3:0][ROWS-1:0] flags_fill;
    logic [3:0][ROWS-1:0] flags_curr;

    matmul_pkg::act_t [SLICES-1:0] act_next;
    matmul_pkg::act_t [SLICES-1:0] act_fill;
    matmul_pkg::act_t [SLICES-1:0] act_curr;

    assign slot_flags = {zero, sign, mul2, div2};

    // newest slot enters at the top, so slot k ends up at rows 3k..3k+2
    always_comb begin
        for (int f = 0; f < 4; f++) begin
            flags_fill[f] = {slot_flags[f], flags_next[f][ROWS-1:RPS]};
        end
    end

    assign act_fill = {act, act_next[SLICES-1:1]};

    always_ff @(posedge clk) begin
        flags_next <= flags_fill;
        act_next   <= act_fill;
        if (group_last) begin
            act_curr <= act_fill;
        end else begin
            // next column moves to the head every cycle
            act_curr <= {act_curr[0], act_curr[SLICES-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset || read_out) begin
            // all rows back to a zero weight
            flags_curr <= {{ROWS{1'b1}}, {(3 * ROWS){1'b0}}};
        end else if (group_last) begin
            flags_curr <= flags_fill;
        end
    end

    assign row_zero = flags_curr[3];
    assign row_sign = flags_curr[2];
    assign row_mul2 = flags_curr[1];
    assign row_div2 = flags_curr[0];
    assign act_head = act_curr[0];

endmodule

`default_nettype wire

/* hw/weight_unpack.sv */
//********************************************************************
// weight unpack
// splits one packed weight byte into a base-5 and two base-7 digits
// and turns each digit into zero/sign/mul2/div2 flags
//********************************************************************

`default_nettype none

module weight_unpack (
    input  matmul_pkg::w_byte_t weights,
    output logic [2:0]          zero,
    output logic [2:0]          sign,
    output logic [2:0]          mul2,
    output logic [2:0]          div2
);

    logic [5:0] upper;
    logic [2:0] digit_low;
    logic [2:0] digit_mid;
    logic [2:0] digit_top;

    // weights 0, 1, 2, -1, -2 as {zero, sign, mul2, div2}
    function automatic logic [3:0] base5_flags(input logic [2:0] digit);
        case (digit)
            3'd1:    base5_flags = 4'b0000;
            3'd2:    base5_flags = 4'b0010;
            3'd3:    base5_flags = 4'b0100;
            3'd4:    base5_flags = 4'b0110;
            default: base5_flags = 4'b1000;
        endcase
    endfunction

    // weights 0, 0.5, 1, 2, -0.5, -1, -2 as {zero, sign, mul2, div2}
    function automatic logic [3:0] base7_flags(input logic [2:0] digit);
        case (digit)
            3'd1:    base7_flags = 4'b0001;
            3'd2:    base7_flags = 4'b0000;
            3'd3:    base7_flags = 4'b0010;
            3'd4:    base7_flags = 4'b0101;
            3'd5:    base7_flags = 4'b0100;
            3'd6:    base7_flags = 4'b0110;
            default: base7_flags = 4'b1000;
        endcase
    endfunction

    always_comb begin
        upper     = 6'(weights / matmul_pkg::BASE5);
        digit_low = 3'(weights % matmul_pkg::BASE5);
        digit_mid = 3'(upper % matmul_pkg::BASE7);
        digit_top = 3'(upper / matmul_pkg::BASE7);

        if (weights < matmul_pkg::WEIGHT_CODES) begin
            {zero[2], sign[2], mul2[2], div2[2]} = base5_flags(digit_low);
            {zero[1], sign[1], mul2[1], div2[1]} = base7_flags(digit_mid);
            {zero[0], sign[0], mul2[0], div2[0]} = base7_flags(digit_top);
        end else begin
            // out of range codes give three zero weights
            zero = 3'b111;
            sign = 3'b000;
            mul2 = 3'b000;
            div2 = 3'b000;
        end

        assert ((mul2 & div2) == 3'b000)
            else $error("weight_unpack: mul2 and div2 set on the same row");
    end

endmodule

`default_nettype wire

/* hw/slice_control.sv */
//********************************************************************
// slice control
// slot counter of the input stream, flags the cycle that carries
// the last slot of a group and restarts on a readout pulse
//********************************************************************

`default_nettype none

module slice_control #(
    parameter int SLICES = 6
) (
    input  logic clk,
    input  logic reset,
    input  logic read_out,
    output logic group_last
);

    localparam int CNT_W = $clog2(SLICES);
    localparam logic [CNT_W-1:0] LAST_SLOT = CNT_W'(SLICES - 1);

    // slot index of the input presented in the current cycle
    logic [CNT_W-1:0] slot;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot <= '0;
        end else if (read_out) begin
            // the readout cycle itself carries slot 0
            slot <= CNT_W'(1);
        end else if (slot == LAST_SLOT) begin
            slot <= '0;
        end else begin
            slot <= slot + 1'b1;
        end
    end

    // a readout cycle is always slot 0 of a new group
    assign group_last = (slot == LAST_SLOT) && !read_out;

    slot_in_range: assert property (@(posedge clk) disable iff (reset) slot < SLICES)
        else $error("slice_control: slot counter left its range");

endmodule

`default_nettype wire

/* hw/matmul_pkg.sv */
//********************************************************************
// matmul package
// shared widths, value types and weight decode constants for the
// outer-product matrix-multiply engine
//********************************************************************

`default_nettype none

package matmul_pkg;

    // one packed byte carries the weights of three rows
    localparam int ROWS_PER_SLOT = 3;

    // valid packed codes are 0 .. 5*7*7-1
    localparam int WEIGHT_CODES = 245;

    // radix of the low digit and of the two upper digits
    localparam int BASE5 = 5;
    localparam int BASE7 = 7;

    // lowest accumulator bit that lands in the result byte
    localparam int OUT_SHIFT = 9;

    typedef logic signed [7:0] act_t;
    typedef logic [7:0] w_byte_t;

    // activation after sign extension and an optional one place shift
    typedef logic signed [8:0] addend_t;

    typedef logic signed [17:0] acc_t;
    typedef logic [7:0] res_t;

endpackage

`default_nettype wire
